/* Makefile */
# Verilator build and run for the rv_core testbench

VERILATOR ?= verilator
TOP       ?= tb_rv_core
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

SOURCES := $(shell cat $(FILELIST))
BIN     := $(BUILD_DIR)/$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -o $(TOP)

sim: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "^STATUS: PASS$$" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* list.f */
rv_pkg.sv
rv_control.sv
rv_imm_gen.sv
rv_regfile.sv
rv_alu.sv
rv_pc_unit.sv
rv_core.sv
tb_rv_core.sv

/* rv_alu.sv */
// rv_alu: add/sub, shifts, compares, logic, pass-b, plus less and zero flags
`timescale 1ns/1ps
`default_nettype none

module rv_alu import rv_pkg::*; (
    input  alu_op_e         op,
    input  logic [xlen-1:0] a,
    input  logic [xlen-1:0] b,
    output logic [xlen-1:0] result,
    output logic            less,
    output logic            zero
);

    logic [4:0] shamt;
    logic       lt_signed;
    logic       lt_unsigned;

    // rv32 shifts use the low 5 bits only
    assign shamt       = b[4:0];
    assign lt_signed   = ($signed(a) < $signed(b));
    assign lt_unsigned = (a < b);

    always_comb begin
        case (op)
            alu_add:    result = a + b;
            alu_sub:    result = a - b;
            alu_sll:    result = a << shamt;
            alu_srl:    result = a >> shamt;
            // arithmetic shift keeps the sign
            alu_sra:    result = $unsigned($signed(a) >>> shamt);
            alu_slt:    result = {{(xlen-1){1'b0}}, lt_signed};
            alu_sltu:   result = {{(xlen-1){1'b0}}, lt_unsigned};
            alu_xor:    result = a ^ b;
            alu_or:     result = a | b;
            alu_and:    result = a & b;
            alu_pass_b: result = b;
            default:    result = '0;
        endcase
    end

    // unsigned compare only for sltu, signed otherwise
    assign less = (op == alu_sltu) ? lt_unsigned : lt_signed;
    // beq/bne look at a - b
    assign zero = (result == '0);

endmodule

`default_nettype wire

/* rv_control.sv */
// rv_control: instruction decode into ctrl_t and branch condition resolve
`timescale 1ns/1ps
`default_nettype none

module rv_control import rv_pkg::*; (
    input  logic [31:0] cmd,
    input  logic        less,
    input  logic        zero,
    output ctrl_t       ctrl,
    output logic        take_branch
);

    opcode_e    opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       alt;
    logic       f7_zero;
    logic       f7_alt;

    assign opcode  = opcode_e'(cmd[6:0]);
    assign funct3  = cmd[14:12];
    assign funct7  = cmd[31:25];
    // bit 30 picks sub / sra
    assign alt     = cmd[30];
    assign f7_zero = (funct7 == 7'b0000000);
    assign f7_alt  = (funct7 == 7'b0100000);

    // funct3 + alt bit to alu function, shared by op and op-imm
    function automatic alu_op_e arith_op(input logic [2:0] f3, input logic sel_alt);
        alu_op_e res;
        case (f3)
            3'b000:  res = sel_alt ? alu_sub : alu_add;
            3'b001:  res = alu_sll;
            3'b010:  res = alu_slt;
            3'b011:  res = alu_sltu;
            3'b100:  res = alu_xor;
            3'b101:  res = sel_alt ? alu_sra : alu_srl;
            3'b110:  res = alu_or;
            default: res = alu_and;
        endcase
        return res;
    endfunction

    always_comb begin
        // defaults: i-type, add, rs1/rs2, no side effects
        ctrl           = '0;
        ctrl.imm_type  = imm_i;
        ctrl.alu_op    = alu_add;
        ctrl.alu_a_src = a_rs1;
        ctrl.alu_b_src = b_rs2;
        case (opcode)
            op_lui: begin
                ctrl.imm_type  = imm_u;
                ctrl.alu_op    = alu_pass_b;
                ctrl.alu_b_src = b_imm;
                ctrl.reg_we    = 1'b1;
            end
            op_auipc: begin
                ctrl.imm_type  = imm_u;
                ctrl.alu_a_src = a_pc;
                ctrl.alu_b_src = b_imm;
                ctrl.reg_we    = 1'b1;
            end
            // jumps: alu makes the link value pc+4
            op_jal: begin
                ctrl.imm_type  = imm_j;
                ctrl.alu_a_src = a_pc;
                ctrl.alu_b_src = b_four;
                ctrl.reg_we    = 1'b1;
                ctrl.is_jal    = 1'b1;
            end
            op_jalr: begin
                ctrl.alu_a_src = a_pc;
                ctrl.alu_b_src = b_four;
                ctrl.reg_we    = 1'b1;
                ctrl.is_jalr   = 1'b1;
                ctrl.illegal   = (funct3 != 3'b000);
            end
            // branches compare rs1 against rs2 in the alu
            op_branch: begin
                ctrl.imm_type  = imm_b;
                ctrl.is_branch = 1'b1;
                case (funct3)
                    3'b000, 3'b001: ctrl.alu_op = alu_sub;
                    3'b100, 3'b101: ctrl.alu_op = alu_slt;
                    3'b110, 3'b111: ctrl.alu_op = alu_sltu;
                    default:        ctrl.illegal = 1'b1;
                endcase
            end
            op_imm: begin
                // bit 30 is immediate data except for srai
                ctrl.alu_op    = arith_op(funct3, alt && (funct3 == 3'b101));
                ctrl.alu_b_src = b_imm;
                ctrl.reg_we    = 1'b1;
                if (funct3 == 3'b001) begin
                    ctrl.illegal = !f7_zero;
                end else if (funct3 == 3'b101) begin
                    ctrl.illegal = !(f7_zero || f7_alt);
                end
            end
            op_reg: begin
                ctrl.alu_op  = arith_op(funct3, alt);
                ctrl.reg_we  = 1'b1;
                ctrl.illegal = !(f7_zero || (f7_alt && (funct3 == 3'b000 || funct3 == 3'b101)));
            end
            default: ctrl.illegal = 1'b1;
        endcase
        // illegal retires as a nop
        if (ctrl.illegal) begin
            ctrl.reg_we    = 1'b0;
            ctrl.is_branch = 1'b0;
            ctrl.is_jal    = 1'b0;
            ctrl.is_jalr   = 1'b0;
        end
    end

    // branch decision from the alu flags
    always_comb begin
        case (funct3)
            3'b000:         take_branch = zero;
            3'b001:         take_branch = !zero;
            3'b100, 3'b110: take_branch = less;
            3'b101, 3'b111: take_branch = !less;
            default:        take_branch = 1'b0;
        endcase
        take_branch = take_branch && ctrl.is_branch;
    end

endmodule

`default_nettype wire

/* rv_core.sv */
// rv_core: single-cycle rv32i top with decode, register file, alu, pc unit and operand muxes
`timescale 1ns/1ps
`default_nettype none

module rv_core import rv_pkg::*; (
    input  logic            clk,
    input  logic            rst_n,
    input  logic [31:0]     cmd,
    output logic [xlen-1:0] pc,
    output logic [xlen-1:0] dnpc,
    output wb_t             wb,
    output logic            illegal
);

    // register indices straight from the word
    logic [4:0]      rs1;
    logic [4:0]      rs2;
    logic [4:0]      rd;
    // decode outputs
    ctrl_t           ctrl;
    logic            take_branch;
    logic [xlen-1:0] imm;
    // data path
    logic [xlen-1:0] src1;
    logic [xlen-1:0] src2;
    logic [xlen-1:0] alu_a;
    logic [xlen-1:0] alu_b;
    logic [xlen-1:0] alu_result;
    logic            less;
    logic            zero;
    logic            pc_offset_sel;

    assign rs1 = cmd[19:15];
    assign rs2 = cmd[24:20];
    assign rd  = cmd[11:7];

    rv_control u_control (
        .cmd         (cmd),
        .less        (less),
        .zero        (zero),
        .ctrl        (ctrl),
        .take_branch (take_branch)
    );

    rv_imm_gen u_imm_gen (
        .cmd      (cmd),
        .imm_type (ctrl.imm_type),
        .imm      (imm)
    );

    rv_regfile u_regfile (
        .clk     (clk),
        .rst_n   (rst_n),
        .raddr_a (rs1),
        .raddr_b (rs2),
        .wb      (wb),
        .rdata_a (src1),
        .rdata_b (src2)
    );

    // operand a: rs1, or pc for auipc and links
    assign alu_a = (ctrl.alu_a_src == a_pc) ? pc : src1;

    // operand b: rs2, immediate, or 4 for links
    always_comb begin
        case (ctrl.alu_b_src)
            b_imm:   alu_b = imm;
            b_four:  alu_b = pc_step;
            default: alu_b = src2;
        endcase
    end

    rv_alu u_alu (
        .op     (ctrl.alu_op),
        .a      (alu_a),
        .b      (alu_b),
        .result (alu_result),
        .less   (less),
        .zero   (zero)
    );

    // redirect on taken branch or any jump
    assign pc_offset_sel = take_branch || ctrl.is_jal || ctrl.is_jalr;

    rv_pc_unit u_pc_unit (
        .clk        (clk),
        .rst_n      (rst_n),
        .offset_sel (pc_offset_sel),
        .base_sel   (ctrl.is_jalr),
        .clear_lsb  (ctrl.is_jalr),
        .imm        (imm),
        .rs1        (src1),
        .pc         (pc),
        .dnpc       (dnpc)
    );

    // write-back trace, x0 writes and reset cycles drop out
    assign wb.valid = ctrl.reg_we && (rd != 5'd0) && rst_n;
    assign wb.rd    = rd;
    // links carry pc+4 from the alu
    assign wb.data  = alu_result;

    assign illegal = ctrl.illegal;

endmodule

`default_nettype wire

/* rv_imm_gen.sv */
// rv_imm_gen: sign-extended immediate for i, s, b, u and j formats
`timescale 1ns/1ps
`default_nettype none

module rv_imm_gen import rv_pkg::*; (
    input  logic [31:0]     cmd,
    input  imm_type_e       imm_type,
    output logic [xlen-1:0] imm
);

    logic sign;

    // sign bit is always inst[31]
    assign sign = cmd[31];

    always_comb begin
        case (imm_type)
            imm_i: begin
                imm = {{20{sign}}, cmd[31:20]};
            end
            imm_s: begin
                imm = {{20{sign}}, cmd[31:25], cmd[11:7]};
            end
            // b and j offsets are in halfwords, bit 0 implied zero
            imm_b: begin
                imm = {{19{sign}}, sign, cmd[7], cmd[30:25], cmd[11:8], 1'b0};
            end
            imm_u: begin
                imm = {cmd[31:12], 12'b0};
            end
            imm_j: begin
                imm = {{11{sign}}, sign, cmd[19:12], cmd[20], cmd[30:21], 1'b0};
            end
            default: begin
                imm = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

/* rv_pc_unit.sv */
// rv_pc_unit: pc register with reset vector and next-pc adder
`timescale 1ns/1ps
`default_nettype none

module rv_pc_unit import rv_pkg::*; (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            offset_sel,
    input  logic            base_sel,
    input  logic            clear_lsb,
    input  logic [xlen-1:0] imm,
    input  logic [xlen-1:0] rs1,
    output logic [xlen-1:0] pc,
    output logic [xlen-1:0] dnpc
);

    logic [xlen-1:0] offset;
    logic [xlen-1:0] base;
    logic [xlen-1:0] sum;

    // imm when taken, else sequential step
    assign offset = offset_sel ? imm : pc_step;
    // rs1 only for jalr
    assign base   = base_sel ? rs1 : pc;
    assign sum    = base + offset;
    // jalr target drops bit 0
    assign dnpc   = clear_lsb ? {sum[xlen-1:1], 1'b0} : sum;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc <= reset_vector;
        end else begin
            pc <= dnpc;
        end
    end

    // no misaligned fetch once running
    assert property (@(posedge clk) disable iff (!rst_n) pc[1:0] == 2'b00)
        else $error("pc not word aligned");

endmodule

`default_nettype wire

/* rv_pkg.sv */
// rv_pkg: core widths, reset vector, opcode/alu/immediate enums, control and write-back structs
`default_nettype none

package rv_pkg;

    // data path width
    localparam int xlen = 32;

    // pc after reset
    localparam logic [xlen-1:0] reset_vector = 32'h8000_0000;

    // sequential pc step and link offset
    localparam logic [xlen-1:0] pc_step = 32'd4;

    // major opcodes, bits [6:0] of the instruction
    typedef enum logic [6:0] {
        op_lui    = 7'b0110111,
        op_auipc  = 7'b0010111,
        op_jal    = 7'b1101111,
        op_jalr   = 7'b1100111,
        op_branch = 7'b1100011,
        op_imm    = 7'b0010011,
        op_reg    = 7'b0110011
    } opcode_e;

    // alu functions
    typedef enum logic [3:0] {
        alu_add    = 4'd0,
        alu_sub    = 4'd1,
        alu_sll    = 4'd2,
        alu_srl    = 4'd3,
        alu_sra    = 4'd4,
        alu_slt    = 4'd5,
        alu_sltu   = 4'd6,
        alu_xor    = 4'd7,
        alu_or     = 4'd8,
        alu_and    = 4'd9,
        // lui, result is operand b
        alu_pass_b = 4'd10
    } alu_op_e;

    // immediate encodings
    typedef enum logic [2:0] {
        imm_i = 3'd0,
        imm_s = 3'd1,
        imm_b = 3'd2,
        imm_u = 3'd3,
        imm_j = 3'd4
    } imm_type_e;

    // alu operand a source
    typedef enum logic {
        a_rs1 = 1'b0,
        a_pc  = 1'b1
    } alu_a_src_e;

    // alu operand b source
    typedef enum logic [1:0] {
        b_rs2  = 2'd0,
        b_imm  = 2'd1,
        b_four = 2'd2
    } alu_b_src_e;

    // decoded control bundle
    typedef struct packed {
        imm_type_e  imm_type;
        alu_op_e    alu_op;
        alu_a_src_e alu_a_src;
        alu_b_src_e alu_b_src;
        logic       reg_we;
        logic       is_branch;
        logic       is_jal;
        logic       is_jalr;
        logic       illegal;
    } ctrl_t;

    // retired register write, 38 bits
    typedef struct packed {
        logic            valid;
        logic [4:0]      rd;
        logic [xlen-1:0] data;
    } wb_t;

endpackage

`default_nettype wire

/* rv_regfile.sv */
// rv_regfile: 32 x 32 register file, two async read ports, one sync write port
`timescale 1ns/1ps
`default_nettype none

module rv_regfile import rv_pkg::*; (
    input  logic            clk,
    input  logic            rst_n,
    input  logic [4:0]      raddr_a,
    input  logic [4:0]      raddr_b,
    input  wb_t             wb,
    output logic [xlen-1:0] rdata_a,
    output logic [xlen-1:0] rdata_b
);

    // x1..x31, x0 has no storage
    logic [xlen-1:0] regs [1:31];

    // write on the edge, held off during reset
    always_ff @(posedge clk) begin
        if (rst_n && wb.valid && (wb.rd != 5'd0)) begin
            regs[wb.rd] <= wb.data;
        end
    end

    // x0 reads as zero
    assign rdata_a = (raddr_a == 5'd0) ? '0 : regs[raddr_a];
    assign rdata_b = (raddr_b == 5'd0) ? '0 : regs[raddr_b];

    // core must already filter x0 writes out of the trace
    assert property (@(posedge clk) disable iff (!rst_n) wb.valid |-> (wb.rd != 5'd0))
        else $error("write-back valid with rd x0");

endmodule

`default_nettype wire

/* tb_rv_core.sv */
// tb_rv_core: directed testbench with instruction memory model, golden registers and compare tasks
`timescale 1ns/1ps
`default_nettype none

module tb_rv_core import rv_pkg::*; ();

    logic            clk;
    logic            rst_n;
    logic [31:0]     cmd;
    logic [xlen-1:0] pc;
    logic [xlen-1:0] dnpc;
    wb_t             wb;
    logic            illegal;

    // program words, index is (pc - reset_vector) / 4
    logic [31:0] imem [0:63];
    // expected architectural registers
    logic [31:0] gold [0:31];
    // expected pc of the next step
    logic [31:0] model_pc;
    int          seed = 32'h19ac;

    // op table for the register-register sweep
    string      op_names [10] = '{"add", "sub", "xor", "or", "and",
                                  "sll", "srl", "sra", "slt", "sltu"};
    logic [2:0] op_f3 [10] = '{3'd0, 3'd0, 3'd4, 3'd6, 3'd7, 3'd1, 3'd5, 3'd5, 3'd2, 3'd3};
    logic       op_alt [10] = '{1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0};

    // branch cases, taken and not taken for each funct3
    logic [2:0] br_f3 [12] = '{3'd0, 3'd0, 3'd1, 3'd1, 3'd4, 3'd4,
                               3'd5, 3'd5, 3'd6, 3'd6, 3'd7, 3'd7};
    logic [4:0] br_rs1 [12] = '{5'd2, 5'd1, 5'd1, 5'd2, 5'd1, 5'd2,
                                5'd2, 5'd1, 5'd2, 5'd1, 5'd1, 5'd2};
    logic [4:0] br_rs2 [12] = '{5'd3, 5'd2, 5'd2, 5'd3, 5'd2, 5'd1,
                                5'd1, 5'd2, 5'd1, 5'd2, 5'd2, 5'd1};
    string      br_names [6] = '{"beq", "bne", "blt", "bge", "bltu", "bgeu"};

    rv_core dut (
        .clk     (clk),
        .rst_n   (rst_n),
        .cmd     (cmd),
        .pc      (pc),
        .dnpc    (dnpc),
        .wb      (wb),
        .illegal (illegal)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // instruction encoders
    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd,
                                          input logic [6:0] opc);
        return {imm, rd, opc};
    endfunction

    // offset in bytes, bit 0 dropped by the format
    function automatic logic [31:0] enc_b(input logic [12:0] off, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] enc_j(input logic [20:0] off, input logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
    endfunction

    function automatic logic [31:0] sext12(input logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    // rv32i result for each entry of the op table
    function automatic logic [31:0] expect_op(input int k, input logic [31:0] a,
                                              input logic [31:0] b);
        case (k)
            0: return a + b;
            1: return a - b;
            2: return a ^ b;
            3: return a | b;
            4: return a & b;
            5: return a << b[4:0];
            6: return a >> b[4:0];
            7: return $unsigned($signed(a) >>> b[4:0]);
            8: return {31'b0, $signed(a) < $signed(b)};
            default: return {31'b0, a < b};
        endcase
    endfunction

    function automatic logic branch_taken(input logic [2:0] f3, input logic [31:0] a,
                                          input logic [31:0] b);
        case (f3)
            3'd0: return a == b;
            3'd1: return a != b;
            3'd4: return $signed(a) < $signed(b);
            3'd5: return $signed(a) >= $signed(b);
            3'd6: return a < b;
            default: return a >= b;
        endcase
    endfunction

    // expected trace entry, rd 0 never shows as valid
    function automatic wb_t wr(input logic [4:0] rd, input logic [31:0] data);
        wb_t w;
        w.valid = (rd != 5'd0);
        w.rd    = rd;
        w.data  = data;
        return w;
    endfunction

    function automatic logic [31:0] fetch(input logic [31:0] addr);
        logic [31:0] idx;
        idx = (addr - reset_vector) >> 2;
        if (idx < 32'd64) begin
            return imem[idx[5:0]];
        end
        // outside the model, addi x0
        return 32'h0000_0013;
    endfunction

    task automatic stop_run(input string line);
        $display("%s", line);
        $display("STATUS: FAIL");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            stop_run($sformatf("[FAIL] %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            stop_run($sformatf("[FAIL] %s: expected %b, actual %b", name, exp, act));
        end
    endtask

    // rd and data only matter on a valid write
    task automatic check_wb(input string name, input wb_t exp, input wb_t act);
        if (act.valid !== exp.valid || (exp.valid && (act.rd !== exp.rd ||
                                                      act.data !== exp.data))) begin
            stop_run({$sformatf("[FAIL] %s: expected valid=%b rd=%0d data=%h",
                                name, exp.valid, exp.rd, exp.data),
                      $sformatf(", actual valid=%b rd=%0d data=%h",
                                act.valid, act.rd, act.data)});
        end
    endtask

    // fill depends on the index, opcode 0 is illegal if ever fetched
    task automatic clear_mem();
        for (int i = 0; i < 64; i++) begin
            imem[i] = {i[24:0], 7'h00};
        end
    endtask

    // called on a falling edge, returns on a falling edge
    task automatic reset_core();
        rst_n = 1'b0;
        // writing word during reset, must stay off the trace
        cmd = enc_i(12'h001, 5'd0, 3'd0, 5'd1, 7'b0010011);
        for (int i = 0; i < 16; i++) begin
            #1;
            check_bit("reset wb.valid", 1'b0, wb.valid);
            @(negedge clk);
        end
        rst_n = 1'b1;
        model_pc = reset_vector;
    endtask

    // one instruction, outputs sampled 1 ns after the falling edge
    task automatic step(input string name, input wb_t exp_wb, input logic [31:0] exp_dnpc,
                        input logic exp_ill);
        cmd = fetch(pc);
        #1;
        check_word({name, " pc"}, model_pc, pc);
        check_wb({name, " wb"}, exp_wb, wb);
        check_word({name, " dnpc"}, exp_dnpc, dnpc);
        check_bit({name, " illegal"}, exp_ill, illegal);
        if (exp_wb.valid) begin
            gold[exp_wb.rd] = exp_wb.data;
        end
        model_pc = exp_dnpc;
        @(negedge clk);
    endtask

    task automatic test_reset();
        clear_mem();
        imem[0] = enc_i(12'h000, 5'd0, 3'd0, 5'd0, 7'b0010011);
        reset_core();
        check_word("reset pc", reset_vector, pc);
        step("reset nop", '0, reset_vector + 32'd4, 1'b0);
    endtask

    task automatic test_arith();
        logic [31:0] v;
        logic [19:0] hi [1:2];
        logic [11:0] lo [1:2];
        for (int round = 0; round < 3; round++) begin
            clear_mem();
            // lui/addi pairs build random x1 and x2
            for (int r = 1; r <= 2; r++) begin
                v = $random(seed);
                lo[r] = v[11:0];
                // addi sign-extends, lui compensates
                hi[r] = v[31:12] + {19'b0, v[11]};
                imem[2*r-2] = enc_u(hi[r], r[4:0], 7'b0110111);
                imem[2*r-1] = enc_i(lo[r], r[4:0], 3'd0, r[4:0], 7'b0010011);
            end
            for (int k = 0; k < 10; k++) begin
                imem[4+k] = enc_r(op_alt[k] ? 7'h20 : 7'h00, 5'd2, 5'd1, op_f3[k], 5'(3 + k));
            end
            reset_core();
            for (int r = 1; r <= 2; r++) begin
                step("lui", wr(r[4:0], {hi[r], 12'h000}), model_pc + 32'd4, 1'b0);
                step("addi", wr(r[4:0], gold[r] + sext12(lo[r])), model_pc + 32'd4, 1'b0);
            end
            for (int k = 0; k < 10; k++) begin
                step(op_names[k], wr(5'(3 + k), expect_op(k, gold[1], gold[2])),
                     model_pc + 32'd4, 1'b0);
            end
        end
    endtask

    task automatic test_x0_auipc();
        clear_mem();
        imem[0] = enc_i(12'h005, 5'd0, 3'd0, 5'd0, 7'b0010011);
        imem[1] = enc_r(7'h00, 5'd0, 5'd0, 3'd0, 5'd13);
        imem[2] = enc_u(20'h12345, 5'd14, 7'b0010111);
        reset_core();
        step("addi x0", wr(5'd0, 32'd5), model_pc + 32'd4, 1'b0);
        step("add from x0", wr(5'd13, 32'd0), model_pc + 32'd4, 1'b0);
        step("auipc", wr(5'd14, model_pc + 32'h1234_5000), model_pc + 32'd4, 1'b0);
    endtask

    task automatic test_branches();
        logic [31:0] rval [1:3];
        logic        taken [12];
        int          idx;
        rval[1] = 32'hffff_fffd;
        rval[2] = 32'd5;
        rval[3] = 32'd5;
        clear_mem();
        imem[0] = enc_i(12'hffd, 5'd0, 3'd0, 5'd1, 7'b0010011);
        imem[1] = enc_i(12'h005, 5'd0, 3'd0, 5'd2, 7'b0010011);
        imem[2] = enc_i(12'h005, 5'd0, 3'd0, 5'd3, 7'b0010011);
        // a taken branch skips one slot
        idx = 3;
        for (int k = 0; k < 12; k++) begin
            taken[k] = branch_taken(br_f3[k], rval[br_rs1[k]], rval[br_rs2[k]]);
            imem[idx] = enc_b(13'd8, br_rs2[k], br_rs1[k], br_f3[k]);
            idx = idx + (taken[k] ? 2 : 1);
        end
        reset_core();
        for (int r = 1; r <= 3; r++) begin
            step("addi setup", wr(r[4:0], rval[r]), model_pc + 32'd4, 1'b0);
        end
        for (int k = 0; k < 12; k++) begin
            step(br_names[k/2], '0, model_pc + (taken[k] ? 32'd8 : 32'd4), 1'b0);
        end
    endtask

    task automatic test_jumps();
        clear_mem();
        imem[0] = enc_u(20'h80000, 5'd1, 7'b0110111);
        imem[1] = enc_i(12'h021, 5'd1, 3'd0, 5'd1, 7'b0010011);
        imem[2] = enc_j(21'd12, 5'd5);
        imem[5] = enc_i(12'h000, 5'd1, 3'd0, 5'd6, 7'b1100111);
        imem[8] = enc_i(12'h004, 5'd1, 3'd0, 5'd7, 7'b1100111);
        // -36 back to the first word
        imem[9] = enc_j(21'h1f_ffdc, 5'd0);
        reset_core();
        step("lui base", wr(5'd1, 32'h8000_0000), model_pc + 32'd4, 1'b0);
        step("addi base", wr(5'd1, gold[1] + sext12(12'h021)), model_pc + 32'd4, 1'b0);
        step("jal", wr(5'd5, model_pc + 32'd4), model_pc + 32'd12, 1'b0);
        step("jalr", wr(5'd6, model_pc + 32'd4), gold[1] & ~32'd1, 1'b0);
        step("jalr offset", wr(5'd7, model_pc + 32'd4), (gold[1] + 32'd4) & ~32'd1, 1'b0);
        step("jal back", wr(5'd0, model_pc + 32'd4), model_pc - 32'd36, 1'b0);
        step("lui again", wr(5'd1, 32'h8000_0000), model_pc + 32'd4, 1'b0);
    endtask

    task automatic test_illegal();
        clear_mem();
        // lw x3, 0(x0), loads are not implemented
        imem[0] = enc_i(12'h000, 5'd0, 3'd2, 5'd3, 7'b0000011);
        imem[1] = 32'hffff_ffff;
        imem[2] = enc_i(12'h000, 5'd0, 3'd0, 5'd0, 7'b0010011);
        reset_core();
        step("load opcode", '0, model_pc + 32'd4, 1'b1);
        step("unknown opcode", '0, model_pc + 32'd4, 1'b1);
        step("nop after illegal", '0, model_pc + 32'd4, 1'b0);
    endtask

    initial begin
        rst_n    = 1'b0;
        cmd      = 32'h0000_0013;
        model_pc = reset_vector;
        gold[0]  = 32'd0;
        @(negedge clk);
        test_reset();
        test_arith();
        test_x0_auipc();
        test_branches();
        test_jumps();
        test_illegal();
        $display("STATUS: PASS");
        $finish;
    end

endmodule

`default_nettype wire
